// File: verification/pipeline_patterns.mem
// program length, program words (from address 0), store count,
// then one store per line as address and data, all hex
00000015
24010005 // addiu $1, $0, 5
24020007 // addiu $2, $0, 7
00221821 // addu  $3, $1, $2
00612023 // subu  $4, $3, $1
ac040000 // sw    $4, 0($0)
ac030004 // sw    $3, 4($0)
8c050004 // lw    $5, 4($0)
00a53021 // addu  $6, $5, $5
ac060008 // sw    $6, 8($0)
10a30002 // beq   $5, $3, taken
ac010020 // sw    $1, 32($0) squashed
ac020020 // sw    $2, 32($0) squashed
14210001 // bne   $1, $1, not taken
0022382a // slt   $7, $1, $2
14e00001 // bne   $7, $0, taken
ac020024 // sw    $2, 36($0) squashed
10e20001 // beq   $7, $2, not taken
00644024 // and   $8, $3, $4
01074825 // or    $9, $8, $7
ac09000c // sw    $9, 12($0)
fc000000 // halt
00000004
00000000 00000007
00000004 0000000c
00000008 00000018
0000000c 00000005

// File: pipeline_datapath.f
logic/cpu_pkg.sv
logic/pipe_latch.sv
logic/fetch_stage.sv
logic/decode_stage.sv
logic/hazard_unit.sv
logic/exec_stage.sv
logic/mem_stage.sv
logic/pipeline_datapath.sv
verification/pipeline_datapath_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS = --binary --timing --assert -j 0
TOP = pipeline_datapath_tb
FILELIST = pipeline_datapath.f
OBJDIR = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: compile
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)

// File: verification/pipeline_datapath_tb.sv
/*
  testbench for the pipelined core
  program image and expected stores from the pattern file,
  wishbone memory models with random wait states,
  ordered store checks, halt checks and cycle timeout
*/
module pipeline_datapath_tb import cpu_pkg::*; ();

  localparam int PAT_WORDS = 256;
  localparam int MEM_WORDS = 256;

  logic CLK = 1'b0;
  logic nRST;
  wb_m2s_t ibus_o;
  wb_s2m_t ibus_i = '0;
  wb_m2s_t dbus_o;
  wb_s2m_t dbus_i = '0;
  logic halt;

  word_t pat [0:PAT_WORDS-1];
  word_t imem [0:MEM_WORDS-1];
  word_t dmem [0:MEM_WORDS-1];
  int prog_len;
  int store_cnt;
  int store_base;
  int stores_seen = 0;
  int cycles = 0;
  int cycle_limit;
  integer seed = 63739;
  int i_delay = 0;
  int d_delay = 0;
  logic i_pend = 1'b0;
  logic d_pend = 1'b0;
  logic halt_seen = 1'b0;
  logic i_cyc_prev = 1'b0;
  logic d_cyc_prev = 1'b0;

  pipeline_datapath #(.PC_INIT(32'h0)) uut (
    .CLK, .nRST, .ibus_o, .ibus_i, .dbus_o, .dbus_i, .halt
  );

  always #50 CLK = ~CLK;

  task automatic stop_on_error();
    $display("FAIL: see errors above");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp)
    begin
      $display("CHECK FAILED at %0t: %s = %h, expected %h", $time, name, got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
      $display("CHECK FAILED at %0t: %s = %b, expected %b", $time, name, got, exp);
      stop_on_error();
    end
  endtask

  // 0 to 3 wait cycles per transfer
  task automatic draw_delay(output int n);
    n = $random(seed) & 3;
  endtask

  // next expected address and data pair, in program order
  task automatic record_store(input word_t adr, input word_t dat);
    if (stores_seen >= store_cnt)
    begin
      $display("an extra store to address %h appeared after all %0d expected stores",
               adr, store_cnt);
      stop_on_error();
    end
    else
    begin
      check_word("dbus_o.adr", adr, pat[store_base + 2 * stores_seen]);
      check_word("dbus_o.dat", dat, pat[store_base + 2 * stores_seen + 1]);
      stores_seen++;
    end
  endtask

  // both slaves answer on the falling edge
  always @(negedge CLK)
  begin
    if (!nRST)
    begin
      ibus_i = '0;
      dbus_i = '0;
      i_pend = 1'b0;
      d_pend = 1'b0;
      for (int k = 0; k < MEM_WORDS; k++)
        dmem[k] = '0;
      check_bit("halt", halt, 1'b0);
      check_bit("ibus_o.cyc", ibus_o.cyc, 1'b0);
      check_bit("dbus_o.cyc", dbus_o.cyc, 1'b0);
    end
    else
    begin
      // instruction port, read only, whole words
      if (ibus_o.cyc && ibus_o.stb)
      begin
        check_bit("ibus_o.we", ibus_o.we, 1'b0);
        check_word("ibus_o.sel", word_t'(ibus_o.sel), 32'hf);
        if (!i_pend)
        begin
          i_pend = 1'b1;
          draw_delay(i_delay);
        end
        if (i_delay == 0)
        begin
          ibus_i.ack = 1'b1;
          ibus_i.dat = imem[ibus_o.adr[9:2]];
          i_pend = 1'b0;
        end
        else
        begin
          ibus_i.ack = 1'b0;
          i_delay--;
        end
      end
      else
      begin
        ibus_i.ack = 1'b0;
        i_pend = 1'b0;
      end
      // data port, master holds adr and dat until the ack edge
      if (dbus_o.cyc && dbus_o.stb)
      begin
        check_word("dbus_o.sel", word_t'(dbus_o.sel), 32'hf);
        if (!d_pend)
        begin
          d_pend = 1'b1;
          draw_delay(d_delay);
        end
        if (d_delay == 0)
        begin
          dbus_i.ack = 1'b1;
          d_pend = 1'b0;
          if (dbus_o.we)
          begin
            record_store(dbus_o.adr, dbus_o.dat);
            dmem[dbus_o.adr[9:2]] = dbus_o.dat;
          end
          else
            dbus_i.dat = dmem[dbus_o.adr[9:2]];
        end
        else
        begin
          dbus_i.ack = 1'b0;
          d_delay--;
        end
      end
      else
      begin
        dbus_i.ack = 1'b0;
        d_pend = 1'b0;
      end
      // halt is sticky, no new bus cycle afterwards
      if (halt_seen)
      begin
        check_bit("halt", halt, 1'b1);
        if ((ibus_o.cyc && !i_cyc_prev) || (dbus_o.cyc && !d_cyc_prev))
        begin
          $display("a bus cycle started after halt at %0t", $time);
          stop_on_error();
        end
      end
      else if (halt)
      begin
        halt_seen = 1'b1;
        check_word("store count at halt", word_t'(stores_seen), word_t'(store_cnt));
      end
      i_cyc_prev = ibus_o.cyc;
      d_cyc_prev = dbus_o.cyc;
    end
  end

  always @(posedge CLK)
  begin
    cycles++;
    if (cycles > cycle_limit)
    begin
      $display("timeout after %0d cycles without a clean halt", cycle_limit);
      stop_on_error();
    end
  end

  initial
  begin
    nRST = 1'b0;
    $readmemh("verification/pipeline_patterns.mem", pat);
    prog_len = int'(pat[0]);
    if ($isunknown(pat[0]) || prog_len < 1 || prog_len > MEM_WORDS - 2)
    begin
      $display("pattern file is missing or has a bad program length");
      stop_on_error();
    end
    store_cnt = int'(pat[prog_len + 1]);
    store_base = prog_len + 2;
    if (store_cnt < 0 || store_base + 2 * store_cnt > PAT_WORDS)
    begin
      $display("pattern file has a bad store count");
      stop_on_error();
    end
    // words past the program read as zero, a bubble
    for (int k = 0; k < MEM_WORDS; k++)
    begin
      if (k < prog_len)
        imem[k] = pat[k + 1];
      else
        imem[k] = '0;
    end
    cycle_limit = 40 * prog_len + 10 * store_cnt;
    repeat (10) @(negedge CLK);
    // slave models still see reset on this edge
    nRST <= 1'b1;
    while (!halt_seen)
      @(posedge CLK);
    // quiet window after halt
    repeat (20) @(posedge CLK);
    $display("PASS: all tests");
    $finish;
  end

endmodule

// File: logic/pipeline_datapath.sv
/*
  core top level
  five stages, four pipeline latches, hazard unit,
  stall and flush combination, writeback and sticky halt
*/
module pipeline_datapath import cpu_pkg::*; #(
  parameter word_t PC_INIT = '0
) (
  input logic CLK,
  input logic nRST,
  output wb_m2s_t ibus_o,
  input wb_s2m_t ibus_i,
  output wb_m2s_t dbus_o,
  input wb_s2m_t dbus_i,
  output logic halt
);

  fetch_pay_t f_out, f_q;
  decode_pay_t d_out, d_q;
  exec_pay_t e_out, e_q;
  mem_pay_t m_out, m_q;
  r_t dec_instr;
  fwd_sel_t fwd_a, fwd_b;
  word_t branch_target;
  word_t wb_word;
  logic branch_taken, fetch_wait, mem_wait, load_stall, flush_front;
  logic stall_front;
  logic stop;

  // front end also holds on load-use
  assign stall_front = mem_wait | load_stall;
  // halt in execute or beyond, nothing younger may proceed
  assign stop = d_q.halt | e_q.halt | halt;
  assign dec_instr = r_t'(f_q.instr);
  assign wb_word = m_q.result;

  fetch_stage #(.PC_INIT(PC_INIT)) fetch (
    .CLK, .nRST, .stall(stall_front), .branch_taken, .branch_target,
    .halt(stop), .ibus_o, .ibus_i, .fetch_wait, .out(f_out)
  );

  // pending fetch alone inserts a bubble here
  pipe_latch #(.payload_t(fetch_pay_t)) fetch_latch (
    .CLK, .nRST, .stall(stall_front),
    .flush((fetch_wait | flush_front | stop) & ~stall_front),
    .d(f_out), .q(f_q)
  );

  decode_stage decode (
    .CLK, .nRST, .in(f_q), .wb_en(m_q.reg_wr), .wb_sel(m_q.wsel),
    .wb_dat(wb_word), .out(d_out)
  );

  // load-use bubble and branch squash enter here
  pipe_latch #(.payload_t(decode_pay_t)) decode_latch (
    .CLK, .nRST, .stall(mem_wait),
    .flush((load_stall | flush_front | stop) & ~mem_wait),
    .d(d_out), .q(d_q)
  );

  hazard_unit hazard (
    .dec_rs(dec_instr.rs), .dec_rt(dec_instr.rt), .ex(d_q), .mem(e_q), .wb(m_q),
    .branch_taken, .fwd_a, .fwd_b, .load_stall, .flush_front
  );

  // memory-stage value is the alu result of the exec latch
  exec_stage exec (
    .in(d_q), .fwd_a, .fwd_b, .mem_fwd(e_q.alu_out), .wb_fwd(wb_word),
    .branch_taken, .branch_target, .out(e_out)
  );

  pipe_latch #(.payload_t(exec_pay_t)) exec_latch (
    .CLK, .nRST, .stall(mem_wait),
    .flush((e_q.halt | halt) & ~mem_wait),
    .d(e_out), .q(e_q)
  );

  mem_stage mem (
    .CLK, .nRST, .in(e_q), .dbus_o, .dbus_i, .mem_wait, .out(m_out)
  );

  pipe_latch #(.payload_t(mem_pay_t)) mem_latch (
    .CLK, .nRST, .stall(mem_wait),
    .flush(halt & ~mem_wait),
    .d(m_out), .q(m_q)
  );

  // sticky until reset
  always_ff @(posedge CLK, negedge nRST)
  begin
    if (!nRST)
      halt <= 1'b0;
    else if (e_q.halt)
      halt <= 1'b1;
  end

endmodule

// File: logic/mem_stage.sv
/*
  memory stage
  data bus master for word loads and stores,
  registered load data and result select
*/
module mem_stage import cpu_pkg::*; (
  input logic CLK,
  input logic nRST,
  input exec_pay_t in,
  output wb_m2s_t dbus_o,
  input wb_s2m_t dbus_i,
  output logic mem_wait,
  output mem_pay_t out
);

  logic access;
  // transfer of the held instruction already acked
  logic done;
  word_t load_q;

  assign access = in.mem_rd | in.mem_wr;
  assign mem_wait = access & ~done;

  always_comb
  begin
    dbus_o.cyc = access & ~done;
    dbus_o.stb = access & ~done;
    dbus_o.we = in.mem_wr;
    dbus_o.adr = in.alu_out;
    dbus_o.dat = in.store_data;
    dbus_o.sel = 4'hf;
  end

  // set on ack, dropped once the latches move on
  always_ff @(posedge CLK, negedge nRST)
  begin
    if (!nRST)
      done <= 1'b0;
    else
      done <= dbus_o.cyc & dbus_i.ack;
  end

  // read data only valid in the ack cycle
  always_ff @(posedge CLK)
  begin
    if (dbus_o.cyc && dbus_i.ack)
      load_q <= dbus_i.dat;
  end

  always_comb
  begin
    out.result = in.mem_rd ? load_q : in.alu_out;
    out.wsel = in.wsel;
    out.reg_wr = in.reg_wr;
    out.halt = in.halt;
  end

  // request held by the frozen exec latch until acked
  assert property (@(posedge CLK) disable iff (!nRST)
    dbus_o.cyc && !dbus_i.ack |=> dbus_o.cyc && dbus_o.stb);

endmodule

// File: logic/exec_stage.sv
/*
  execute stage
  forwarded operand muxes, ALU, branch compare and target
*/
module exec_stage import cpu_pkg::*; (
  input decode_pay_t in,
  input fwd_sel_t fwd_a,
  input fwd_sel_t fwd_b,
  input word_t mem_fwd,
  input word_t wb_fwd,
  output logic branch_taken,
  output word_t branch_target,
  output exec_pay_t out
);

  word_t opa;
  word_t opb_reg;
  word_t opb;
  word_t result;

  function automatic word_t pick(fwd_sel_t sel, word_t rf, word_t m, word_t w);
    word_t v;
    case (sel)
      FROM_MEM: v = m;
      FROM_WB: v = w;
      default: v = rf;
    endcase
    return v;
  endfunction

  assign opa = pick(fwd_a, in.rdat1, mem_fwd, wb_fwd);
  assign opb_reg = pick(fwd_b, in.rdat2, mem_fwd, wb_fwd);
  // immediate for addiu, lw, sw
  assign opb = in.alu_src ? in.imm : opb_reg;

  always_comb
  begin
    case (in.aluop)
      ALU_SUB: result = opa - opb;
      ALU_AND: result = opa & opb;
      ALU_OR: result = opa | opb;
      ALU_SLT: result = {31'b0, $signed(opa) < $signed(opb)};
      default: result = opa + opb;
    endcase
  end

  // beq on equal, bne on not equal
  assign branch_taken = in.branch && ((opa == opb_reg) != in.branch_ne);
  assign branch_target = in.pc + 32'd4 + {in.imm[29:0], 2'b00};

  always_comb
  begin
    out.alu_out = result;
    out.store_data = opb_reg;
    out.wsel = in.wsel;
    out.reg_wr = in.reg_wr;
    out.mem_rd = in.mem_rd;
    out.mem_wr = in.mem_wr;
    out.halt = in.halt;
  end

endmodule

// File: logic/hazard_unit.sv
/*
  hazard unit
  operand forwarding selects, load-use stall, branch flush
*/
module hazard_unit import cpu_pkg::*; (
  input regsel_t dec_rs,
  input regsel_t dec_rt,
  input decode_pay_t ex,
  input exec_pay_t mem,
  input mem_pay_t wb,
  input logic branch_taken,
  output fwd_sel_t fwd_a,
  output fwd_sel_t fwd_b,
  output logic load_stall,
  output logic flush_front
);

  // youngest producer first, r0 is never forwarded
  function automatic fwd_sel_t pick_src(regsel_t r, exec_pay_t m, mem_pay_t w);
    fwd_sel_t sel;
    sel = NONE;
    if (r != '0)
    begin
      if (m.reg_wr && m.wsel == r)
        sel = FROM_MEM;
      else if (w.reg_wr && w.wsel == r)
        sel = FROM_WB;
    end
    return sel;
  endfunction

  assign fwd_a = pick_src(ex.rs, mem, wb);
  assign fwd_b = pick_src(ex.rt, mem, wb);

  // load in execute feeding the instruction in decode
  assign load_stall = ex.mem_rd && ex.wsel != '0 &&
                      (ex.wsel == dec_rs || ex.wsel == dec_rt);

  // squash the two younger slots
  assign flush_front = branch_taken;

endmodule

// File: logic/decode_stage.sv
/*
  decode stage
  control decode, immediate sign extension, destination select
  and the 32 x 32 register file with write-to-read bypass
*/
module decode_stage import cpu_pkg::*; (
  input logic CLK,
  input logic nRST,
  input fetch_pay_t in,
  input logic wb_en,
  input regsel_t wb_sel,
  input word_t wb_dat,
  output decode_pay_t out
);

  word_t regs [0:31];
  r_t rin;
  i_t iin;
  word_t rdat1;
  word_t rdat2;

  assign rin = r_t'(in.instr);
  assign iin = i_t'(in.instr);

  // register file, written in writeback, r0 never written
  always_ff @(posedge CLK, negedge nRST)
  begin
    if (!nRST)
    begin
      for (int i = 0; i < 32; i++)
        regs[i] <= '0;
    end
    else if (wb_en && wb_sel != '0)
      regs[wb_sel] <= wb_dat;
  end

  // same-cycle writeback bypass
  assign rdat1 = (rin.rs == '0) ? '0 :
                 (wb_en && wb_sel == rin.rs) ? wb_dat : regs[rin.rs];
  assign rdat2 = (rin.rt == '0) ? '0 :
                 (wb_en && wb_sel == rin.rt) ? wb_dat : regs[rin.rt];

  always_comb
  begin
    // start from a bubble
    out = '0;
    out.pc = in.pc;
    out.rs = rin.rs;
    out.rt = rin.rt;
    out.rdat1 = rdat1;
    out.rdat2 = rdat2;
    out.imm = {{16{iin.imm[15]}}, iin.imm};
    out.aluop = ALU_ADD;
    case (rin.opcode)
      RTYPE:
      begin
        out.wsel = rin.rd;
        out.reg_wr = 1'b1;
        case (rin.funct)
          ADDU: out.aluop = ALU_ADD;
          SUBU: out.aluop = ALU_SUB;
          AND: out.aluop = ALU_AND;
          OR: out.aluop = ALU_OR;
          SLT: out.aluop = ALU_SLT;
          // unknown funct, stays a bubble
          default: out.reg_wr = 1'b0;
        endcase
      end
      ADDIU:
      begin
        out.wsel = rin.rt;
        out.alu_src = 1'b1;
        out.reg_wr = 1'b1;
      end
      LW:
      begin
        out.wsel = rin.rt;
        out.alu_src = 1'b1;
        out.reg_wr = 1'b1;
        out.mem_rd = 1'b1;
      end
      SW:
      begin
        out.alu_src = 1'b1;
        out.mem_wr = 1'b1;
      end
      BEQ:
        out.branch = 1'b1;
      BNE:
      begin
        out.branch = 1'b1;
        out.branch_ne = 1'b1;
      end
      HALT:
        out.halt = 1'b1;
      default:
        out.halt = 1'b0;
    endcase
  end

endmodule

// File: logic/fetch_stage.sv
/*
  fetch stage
  program counter, pending redirect and the
  read-only instruction bus master
*/
module fetch_stage import cpu_pkg::*; #(
  parameter word_t PC_INIT = '0
) (
  input logic CLK,
  input logic nRST,
  input logic stall,
  input logic branch_taken,
  input word_t branch_target,
  input logic halt,
  output wb_m2s_t ibus_o,
  input wb_s2m_t ibus_i,
  output logic fetch_wait,
  output fetch_pay_t out
);

  word_t pc;
  word_t redir_pc;
  logic redir;
  // read already under way, must finish even after halt
  logic busy;
  logic req;

  // bus idle while in reset
  assign req = nRST & (~halt | busy);

  always_comb
  begin
    ibus_o.cyc = req;
    ibus_o.stb = req;
    ibus_o.we = 1'b0;
    ibus_o.adr = pc;
    ibus_o.dat = '0;
    ibus_o.sel = 4'hf;
  end

  // word usable only if no redirect is queued behind it
  assign fetch_wait = ~(req & ibus_i.ack & ~redir);
  assign out.pc = pc;
  assign out.instr = ibus_i.dat;

  always_ff @(posedge CLK, negedge nRST)
  begin
    if (!nRST)
    begin
      pc <= PC_INIT;
      redir <= 1'b0;
      redir_pc <= '0;
      busy <= 1'b0;
    end
    else if (req && ibus_i.ack)
    begin
      busy <= 1'b0;
      redir <= 1'b0;
      // branch or queued target wins, word is dropped
      if (branch_taken)
        pc <= branch_target;
      else if (redir)
        pc <= redir_pc;
      else if (!stall)
        pc <= pc + 32'd4;
      // stalled ack, same pc is simply read again
    end
    else
    begin
      busy <= req;
      // adr must stay put, remember the target for later
      if (branch_taken)
      begin
        redir <= 1'b1;
        redir_pc <= branch_target;
      end
    end
  end

  assert property (@(posedge CLK) disable iff (!nRST)
    ibus_o.stb && !ibus_i.ack |=> ibus_o.stb && $stable(ibus_o.adr));

endmodule

// File: logic/pipe_latch.sv
/*
  generic pipeline register between two stages
  stall holds, flush loads a bubble (all zero)
*/
module pipe_latch import cpu_pkg::*; #(
  parameter type payload_t = fetch_pay_t
) (
  input logic CLK,
  input logic nRST,
  input logic stall,
  input logic flush,
  input payload_t d,
  output payload_t q
);

  always_ff @(posedge CLK, negedge nRST)
  begin
    if (!nRST)
      q <= '0;
    else if (stall)
      q <= q;
    else if (flush)
      q <= '0;
    else
      q <= d;
  end

  // top level gates flush with stall
  assert property (@(posedge CLK) disable iff (!nRST) !(stall && flush));

endmodule

// File: logic/cpu_pkg.sv
/*
  shared types for the five-stage MIPS subset core
  instruction layouts, opcode and funct encodings, ALU ops,
  stage payload structs, forwarding selects, Wishbone bus structs
*/
package cpu_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0] regsel_t;

  // major opcode, instr[31:26]
  typedef enum logic [5:0] {
    RTYPE = 6'h00,
    BEQ   = 6'h04,
    BNE   = 6'h05,
    ADDIU = 6'h09,
    LW    = 6'h23,
    SW    = 6'h2b,
    HALT  = 6'h3f
  } opcode_t;

  // r-type function field, instr[5:0]
  typedef enum logic [5:0] {
    ADDU = 6'h21,
    SUBU = 6'h23,
    AND  = 6'h24,
    OR   = 6'h25,
    SLT  = 6'h2a
  } funct_t;

  typedef struct packed {
    opcode_t opcode;
    regsel_t rs;
    regsel_t rt;
    regsel_t rd;
    logic [4:0] shamt;
    funct_t funct;
  } r_t;

  typedef struct packed {
    opcode_t opcode;
    regsel_t rs;
    regsel_t rt;
    logic [15:0] imm;
  } i_t;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_SLT
  } aluop_t;

  // fetch -> decode
  typedef struct packed {
    word_t pc;
    word_t instr;
  } fetch_pay_t;

  // decode -> execute, all-zero control is a bubble
  typedef struct packed {
    word_t pc;
    regsel_t rs;
    regsel_t rt;
    regsel_t wsel;
    word_t rdat1;
    word_t rdat2;
    word_t imm;
    aluop_t aluop;
    logic alu_src;
    logic reg_wr;
    logic mem_rd;
    logic mem_wr;
    logic branch;
    logic branch_ne;
    logic halt;
  } decode_pay_t;

  // execute -> memory
  typedef struct packed {
    word_t alu_out;
    word_t store_data;
    regsel_t wsel;
    logic reg_wr;
    logic mem_rd;
    logic mem_wr;
    logic halt;
  } exec_pay_t;

  // memory -> writeback
  typedef struct packed {
    word_t result;
    regsel_t wsel;
    logic reg_wr;
    logic halt;
  } mem_pay_t;

  typedef enum logic [1:0] {
    NONE,
    FROM_MEM,
    FROM_WB
  } fwd_sel_t;

  // wishbone classic, master side
  typedef struct packed {
    logic cyc;
    logic stb;
    logic we;
    word_t adr;
    word_t dat;
    logic [3:0] sel;
  } wb_m2s_t;

  // wishbone classic, slave side
  typedef struct packed {
    logic ack;
    word_t dat;
  } wb_s2m_t;

endpackage
